// File: tb.f
verilog/bnn_geom_pkg.sv
verilog/bnn_op_pkg.sv
verilog/bnn_ctrl_if.sv
verilog/bnn_ctrl.sv
verilog/ifmap_window.sv
verilog/weight_bank.sv
verilog/bnn_result.sv
verilog/bnn_alu.sv
dv/clk_gen.sv
dv/tb_bnn_alu.sv

// File: Makefile
TOP = tb_bnn_alu
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "No errors" $(LOG)

lint:
	verilator --lint-only --timing -sv -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_bnn_alu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_bnn_alu import bnn_geom_pkg::*, bnn_op_pkg::*; ();

    // cols[i] is the column entered at shift i
    typedef struct packed {
        op_e                     op;
        kernel_onehot_t          ks;
        logic                    en;
        window_bits_t            wt;
        row_bits_t [WIN_DIM-1:0] cols;
        mac_t                    exp;
    } vec_t;

    localparam int N_DIR  = 14;
    localparam int N_RAND = 40;

    logic           clk;
    logic           rst_n;
    logic           enable;
    logic           load_ifmaps;
    logic           load_weight;
    row_bits_t      ifmap_col;
    window_bits_t   weight_in;
    op_e            operation;
    kernel_onehot_t kernel_size;
    mac_t           mac_out;

    vec_t         vecs [N_DIR];
    window_bits_t model_win;
    window_bits_t model_wt;
    int           model_wt_k;
    logic [15:0]  lfsr;

    clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    bnn_alu i_bnn_alu (.*);

    function automatic int size_of(input kernel_onehot_t ks);
        int k;
        k = 1;
        for (int n = 0; n < WIN_DIM; n++) begin
            if (ks[n]) begin
                k = n + 1;
            end
        end
        return k;
    endfunction

    // rows 0..k-1, columns 5-k..4
    function automatic window_bits_t mask_for_size(input int k);
        window_bits_t m;
        m = '0;
        for (int r = 0; r < k; r++) begin
            for (int c = WIN_DIM - k; c < WIN_DIM; c++) begin
                m[r*WIN_DIM + c] = 1'b1;
            end
        end
        return m;
    endfunction

    function automatic mac_t expected_mac(input op_e op, input logic en, input int k);
        window_bits_t m;
        int           hits;
        m    = mask_for_size(k);
        hits = 0;
        if (!en || (op != OP_CONV && op != OP_POOL)) begin
            return '0;
        end
        if (op == OP_POOL) begin
            return (|(model_win & m)) ? mac_t'(1) : mac_t'(0);
        end
        for (int i = 0; i < WIN_CELLS; i++) begin
            if (m[i] && model_win[i] == model_wt[i]) begin
                hits++;
            end
        end
        return mac_t'(2 * hits - k * k);
    endfunction

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_mac(input string name, input mac_t exp, input mac_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, got %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            $display("Errors found");
            $fatal(1, "reset timeout");
        end
    endtask

    // one weight load, five shifts, then sample on the falling edge
    task automatic apply_row(input vec_t v);
        int k;
        k = size_of(v.ks);
        @(posedge clk);
        enable      <= v.en;
        operation   <= v.op;
        kernel_size <= v.ks;
        weight_in   <= v.wt;
        load_weight <= 1'b1;
        @(posedge clk);
        load_weight <= 1'b0;
        load_ifmaps <= 1'b1;
        if (v.op == OP_CONV) begin
            model_wt   = v.en ? (v.wt | ~mask_for_size(k)) : '1;
            model_wt_k = v.en ? k : 1;
        end
        for (int i = 0; i < WIN_DIM; i++) begin
            ifmap_col <= v.cols[i];
            for (int r = 0; r < WIN_DIM; r++) begin
                model_win[r*WIN_DIM +: WIN_DIM] =
                    {v.en & v.cols[i][r], model_win[r*WIN_DIM + 1 +: WIN_DIM - 1]};
            end
            model_win = model_win & mask_for_size(k);
            @(posedge clk);
        end
        load_ifmaps <= 1'b0;
        @(negedge clk);
    endtask

    // empty window against all-one weights gives minus the area
    task automatic check_empty_conv();
        for (int n = 0; n < WIN_DIM; n++) begin
            @(posedge clk);
            enable      <= 1'b1;
            operation   <= OP_CONV;
            kernel_size <= 5'd1 << n;
            @(negedge clk);
            check_mac("mac_out", mac_t'(-(n + 1) * (n + 1)), mac_out);
        end
    endtask

    task automatic follow_up(input vec_t v);
        int k;
        k = size_of(v.ks);
        if (!v.en && v.op == OP_CONV) begin
            check_empty_conv();
        end else if (v.en && v.op == OP_POOL && model_wt_k <= k) begin
            // weights must have survived the load under pooling
            @(posedge clk);
            operation <= OP_CONV;
            @(negedge clk);
            check_mac("mac_out", expected_mac(OP_CONV, 1'b1, k), mac_out);
        end
    endtask

    task automatic random_row(output vec_t v);
        logic [31:0] bits;
        take_bits(2, bits);
        v.op = op_e'(bits[1:0]);
        take_bits(3, bits);
        v.ks = (bits[2:0] < 3'd5) ? (5'd1 << bits[2:0]) : 5'd0;
        take_bits(3, bits);
        v.en = (bits[2:0] != 3'd0);
        take_bits(WIN_CELLS, bits);
        v.wt = bits[WIN_CELLS-1:0];
        for (int i = 0; i < WIN_DIM; i++) begin
            take_bits(WIN_DIM, bits);
            v.cols[i] = bits[WIN_DIM-1:0];
        end
        v.exp = '0;
    endtask

    initial begin
        vec_t v;
        enable      = 1'b0;
        load_ifmaps = 1'b0;
        load_weight = 1'b0;
        ifmap_col   = '0;
        weight_in   = '0;
        operation   = OP_CONV;
        kernel_size = '0;
        lfsr        = 16'd26122;
        model_win   = '0;
        model_wt    = '1;
        model_wt_k  = 1;

        // op, size, enable, weights, columns {c4..c0}, expected
        vecs[0]  = '{OP_CONV, 5'b10000, 1'b1, 25'h1ffffff, {5{5'h1f}}, 6'sd25};
        vecs[1]  = '{OP_CONV, 5'b10000, 1'b1, 25'h0, {5{5'h1f}}, -6'sd25};
        vecs[2]  = '{OP_CONV, 5'b00001, 1'b1, 25'h0, 25'h0, 6'sd1};
        vecs[3]  = '{OP_CONV, 5'b00100, 1'b1, 25'h1ffffff, {5{5'h1f}}, 6'sd9};
        vecs[4]  = '{OP_CONV, 5'b00100, 1'b1, 25'h000739c,
                     {5'h07, 5'h07, 5'h07, 5'h1f, 5'h1f}, 6'sd9};
        vecs[5]  = '{OP_CONV, 5'b00010, 1'b1, 25'h1ffffff, {5'h02, 5'h01, 15'h0}, 6'sd0};
        vecs[6]  = '{OP_CONV, 5'b01000, 1'b1, 25'h0, 25'h0, 6'sd16};
        vecs[7]  = '{OP_POOL, 5'b10000, 1'b1, 25'h0, 25'h0, 6'sd0};
        vecs[8]  = '{OP_POOL, 5'b00100, 1'b1, 25'h0, {10'h0, 5'h04, 10'h0}, 6'sd1};
        vecs[9]  = '{OP_POOL, 5'b00010, 1'b1, 25'h0, {10'h0, 5'h04, 5'h0, 5'h1f}, 6'sd0};
        vecs[10] = '{OP_CONV, 5'b10000, 1'b0, 25'h0, {5{5'h1f}}, 6'sd0};
        vecs[11] = '{op_e'(2'd2), 5'b10000, 1'b1, 25'h0, {5{5'h1f}}, 6'sd0};
        vecs[12] = '{op_e'(2'd3), 5'b00100, 1'b1, 25'h0, {5{5'h1f}}, 6'sd0};
        vecs[13] = '{OP_POOL, 5'b10000, 1'b0, 25'h0, {5{5'h1f}}, 6'sd0};

        wait_reset_release();
        @(negedge clk);
        check_mac("mac_out", '0, mac_out);
        check_empty_conv();

        for (int i = 0; i < N_DIR; i++) begin
            apply_row(vecs[i]);
            check_mac("mac_out", vecs[i].exp, mac_out);
            check_mac("mac_out", expected_mac(vecs[i].op, vecs[i].en, size_of(vecs[i].ks)),
                      mac_out);
            follow_up(vecs[i]);
        end

        for (int i = 0; i < N_RAND; i++) begin
            random_row(v);
            apply_row(v);
            check_mac("mac_out", expected_mac(v.op, v.en, size_of(v.ks)), mac_out);
            follow_up(v);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for 8 cycles
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/bnn_alu.sv
`timescale 1ns/100ps
`default_nettype none

module bnn_alu import bnn_geom_pkg::*, bnn_op_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           enable,
    input  logic           load_ifmaps,
    input  logic           load_weight,
    input  row_bits_t      ifmap_col,
    input  window_bits_t   weight_in,
    input  op_e            operation,
    input  kernel_onehot_t kernel_size,
    output mac_t           mac_out
);

    window_bits_t ifmap_cells;
    window_bits_t weight_cells;

    bnn_ctrl_if ctrl_bus ();

    bnn_ctrl i_bnn_ctrl (
        .enable      (enable),
        .load_ifmaps (load_ifmaps),
        .load_weight (load_weight),
        .operation   (operation),
        .kernel_size (kernel_size),
        .cif         (ctrl_bus)
    );

    ifmap_window i_ifmap_window (
        .clk         (clk),
        .rst_n       (rst_n),
        .ifmap_col   (ifmap_col),
        .cif         (ctrl_bus),
        .ifmap_cells (ifmap_cells)
    );

    weight_bank i_weight_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .weight_in    (weight_in),
        .cif          (ctrl_bus),
        .weight_cells (weight_cells)
    );

    // combinational, so register updates show up right after the edge
    bnn_result i_bnn_result (
        .ifmap_cells  (ifmap_cells),
        .weight_cells (weight_cells),
        .cif          (ctrl_bus),
        .mac_out      (mac_out)
    );

endmodule

`default_nettype wire

// File: verilog/bnn_result.sv
`timescale 1ns/100ps
`default_nettype none

module bnn_result import bnn_geom_pkg::*, bnn_op_pkg::*; (
    input  window_bits_t ifmap_cells,
    input  window_bits_t weight_cells,
    bnn_ctrl_if.result   cif,
    output mac_t         mac_out
);

    window_bits_t match;
    logic [1:0]   sum_l1 [12];
    logic [2:0]   sum_l2 [6];
    logic [3:0]   sum_l3 [3];
    logic [4:0]   sum_l4 [2];
    logic [4:0]   match_cnt;
    mac_t         conv_val;
    mac_t         pool_val;

    assign match = ifmap_cells ~^ weight_cells;

    // popcount tree, cell 24 joins at level 4
    always_comb begin
        for (int i = 0; i < 12; i++) begin
            sum_l1[i] = 2'(match[2*i]) + 2'(match[2*i + 1]);
        end
        for (int i = 0; i < 6; i++) begin
            sum_l2[i] = 3'(sum_l1[2*i]) + 3'(sum_l1[2*i + 1]);
        end
        for (int i = 0; i < 3; i++) begin
            sum_l3[i] = 4'(sum_l2[2*i]) + 4'(sum_l2[2*i + 1]);
        end
        sum_l4[0] = 5'(sum_l3[0]) + 5'(sum_l3[1]);
        sum_l4[1] = 5'(sum_l3[2]) + 5'(match[WIN_CELLS-1]);
        match_cnt = sum_l4[0] + sum_l4[1];
    end

    // matches minus mismatches over the kernel
    assign conv_val = mac_t'({match_cnt, 1'b0}) - mac_t'({1'b0, cif.kernel_area});

    assign pool_val = mac_t'({{(MAC_W-1){1'b0}}, |ifmap_cells});

    always_comb begin
        case (cif.result_sel)
            SEL_CONV: mac_out = conv_val;
            SEL_POOL: mac_out = pool_val;
            default:  mac_out = '0;
        endcase
    end

    // holds only while no cell outside the mask matches
    always_comb begin
        assert final (cif.result_sel != SEL_CONV || (mac_out >= -25 && mac_out <= 25))
            else $error("bnn_result: convolution result %0d out of range", mac_out);
    end

endmodule

`default_nettype wire

// File: verilog/weight_bank.sv
`timescale 1ns/100ps
`default_nettype none

module weight_bank import bnn_geom_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  window_bits_t weight_in,
    bnn_ctrl_if.weights  cif,
    output window_bits_t weight_cells
);

    window_bits_t load_val;

    // unmasked cells hold 1 so a zero ifmap bit there never matches
    always_comb begin
        load_val = weight_in | ~cif.kernel_mask | {WIN_CELLS{cif.weight_fill}};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_cells <= '1;
        end else if (cif.weight_load_en) begin
            weight_cells <= load_val;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ifmap_window.sv
`timescale 1ns/100ps
`default_nettype none

module ifmap_window import bnn_geom_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  row_bits_t    ifmap_col,
    bnn_ctrl_if.window   cif,
    output window_bits_t ifmap_cells
);

    window_bits_t shifted;

    // each row moves one column toward column 0
    always_comb begin
        for (int r = 0; r < WIN_DIM; r++) begin
            for (int c = 0; c < WIN_DIM; c++) begin
                if (c == WIN_DIM - 1) begin
                    shifted[r*WIN_DIM + c] = cif.shift_zero ? 1'b0 : ifmap_col[r];
                end else begin
                    shifted[r*WIN_DIM + c] = ifmap_cells[r*WIN_DIM + c + 1];
                end
            end
        end
    end

    // clearing unmasked cells gives the zero padding
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifmap_cells <= '0;
        end else if (cif.shift_en) begin
            ifmap_cells <= shifted & cif.kernel_mask;
        end
    end

    // bits pushed past the kernel's left edge must be gone
    assert property (@(posedge clk) disable iff (!rst_n)
        cif.shift_en |=> (ifmap_cells & ~$past(cif.kernel_mask)) == '0)
        else $error("ifmap_window: cell outside kernel mask set after shift");

endmodule

`default_nettype wire

// File: verilog/bnn_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module bnn_ctrl import bnn_geom_pkg::*, bnn_op_pkg::*; (
    input  logic           enable,
    input  logic           load_ifmaps,
    input  logic           load_weight,
    input  op_e            operation,
    input  kernel_onehot_t kernel_size,
    bnn_ctrl_if.ctrl       cif
);

    logic [2:0]   k_dim;
    window_bits_t mask;

    // highest set bit wins, all zero falls back to 1x1
    always_comb begin
        k_dim = 3'd1;
        for (int n = 0; n < WIN_DIM; n++) begin
            if (kernel_size[n]) begin
                k_dim = 3'(n + 1);
            end
        end
    end

    // rows 0..k-1, rightmost k columns
    always_comb begin
        for (int r = 0; r < WIN_DIM; r++) begin
            for (int c = 0; c < WIN_DIM; c++) begin
                mask[r*WIN_DIM + c] = (r < k_dim) && (c >= WIN_DIM - k_dim);
            end
        end
    end

    assign cif.kernel_mask    = mask;
    assign cif.kernel_area    = kernel_area_t'(k_dim) * kernel_area_t'(k_dim);
    assign cif.shift_en       = load_ifmaps;
    assign cif.shift_zero     = ~enable;
    // weights only load for convolution
    assign cif.weight_load_en = load_weight && (operation == OP_CONV);
    assign cif.weight_fill    = ~enable;

    always_comb begin
        if (!enable) begin
            cif.result_sel = SEL_ZERO;
        end else begin
            case (operation)
                OP_CONV: cif.result_sel = SEL_CONV;
                OP_POOL: cif.result_sel = SEL_POOL;
                default: cif.result_sel = SEL_ZERO;
            endcase
        end
    end

    // multi-hot size would decode differently from the area and mask seen downstream
    always_comb begin
        assert final (!enable || $onehot0(kernel_size))
            else $error("bnn_ctrl: multi-hot kernel_size %b while enabled", kernel_size);
    end

endmodule

`default_nettype wire

// File: verilog/bnn_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface bnn_ctrl_if import bnn_geom_pkg::*, bnn_op_pkg::*; ();

    logic         shift_en;
    logic         shift_zero;
    logic         weight_load_en;
    logic         weight_fill;
    window_bits_t kernel_mask;
    kernel_area_t kernel_area;
    result_sel_e  result_sel;

    modport ctrl (
        output shift_en, shift_zero, weight_load_en, weight_fill,
        output kernel_mask, kernel_area, result_sel
    );

    modport window (input shift_en, shift_zero, kernel_mask);

    modport weights (input weight_load_en, weight_fill, kernel_mask);

    modport result (input kernel_area, result_sel);

endinterface

`default_nettype wire

// File: verilog/bnn_op_pkg.sv
`default_nettype none

package bnn_op_pkg;

    // codes 2 and 3 have no datapath and give a zero result
    typedef enum logic [1:0] {
        OP_CONV = 2'd0,
        OP_POOL = 2'd1
    } op_e;

    // output mux select
    typedef enum logic [1:0] {
        SEL_ZERO = 2'd0,
        SEL_CONV = 2'd1,
        SEL_POOL = 2'd2
    } result_sel_e;

endpackage

`default_nettype wire

// File: verilog/bnn_geom_pkg.sv
`default_nettype none

package bnn_geom_pkg;

    // window side and cell count
    localparam int WIN_DIM   = 5;
    localparam int WIN_CELLS = WIN_DIM * WIN_DIM;

    // signed result width, holds -25 .. 25
    localparam int MAC_W = 6;

    // cell index is row * WIN_DIM + column, column 4 is the entry edge
    typedef logic [WIN_CELLS-1:0] window_bits_t;

    // one bit per row, as entered in one shift
    typedef logic [WIN_DIM-1:0] row_bits_t;

    // bit n set means a kernel of size n+1
    typedef logic [WIN_DIM-1:0] kernel_onehot_t;

    // 1, 4, 9, 16 or 25
    typedef logic [$clog2(WIN_CELLS+1)-1:0] kernel_area_t;

    typedef logic signed [MAC_W-1:0] mac_t;

endpackage

`default_nettype wire
